/* run.sh */
#!/bin/sh
# Build and run the hazard-control testbench with Verilator

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f tb.f --top-module hazardTb -Mdir "$OBJ" -o hazardSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/hazardSim" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi

/* source/forwardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hazard_consts.svh"

module forwardUnit import hazardPkg::*; (
	input  hzStage_t idInfo,
	input  hzStage_t exQ,
	input  hzStage_t memQ,
	input  hzStage_t wbQ,
	output hzFwd_t   fwd
);

	// Stage holds a live GPR result for this register
	function automatic logic producerHit(
		input hzStage_t             st,
		input logic [`HZ_REG_W-1:0] src
	);
		producerHit = st.valid && st.rfWr &&
			(st.dst != `HZ_ZERO_REG) && (st.dst == src);
	endfunction

	function automatic hzFwdSrc_t exSelect(
		input hzStage_t             memSt,
		input hzStage_t             wbSt,
		input logic [`HZ_REG_W-1:0] src
	);
		if (producerHit(memSt, src))
			exSelect = FWD_MEM;  // Youngest result wins
		else if (producerHit(wbSt, src))
			exSelect = FWD_WB;
		else
			exSelect = FWD_NONE;
	endfunction

	logic memRsHit;
	logic memRtHit;

	assign memRsHit = producerHit(memQ, exQ.rs);
	assign memRtHit = producerHit(memQ, exQ.rt);

	always_comb begin
		fwd.exRs = exSelect(memQ, wbQ, exQ.rs);
		fwd.exRt = exSelect(memQ, wbQ, exQ.rt);
		// Only the branch comparator taps MEM in ID
		fwd.idRs = idInfo.bjOp && producerHit(memQ, idInfo.rs);
		fwd.idRt = idInfo.bjOp && producerHit(memQ, idInfo.rt);
	end

	// A stale WB value must never shadow a newer MEM result
	always_comb begin
		if (fwd.exRs == FWD_WB) begin
			assert (!memRsHit)
			else $error("forwardUnit: rs took WB over matching MEM");
		end
		if (fwd.exRt == FWD_WB) begin
			assert (!memRtHit)
			else $error("forwardUnit: rt took WB over matching MEM");
		end
	end

endmodule

`default_nettype wire

/* source/hazardPkg.sv */
`default_nettype none

`include "hazard_consts.svh"

package hazardPkg;

	// Per-instruction register usage, carried down EX/MEM/WB
	typedef struct packed {
		logic                 valid;
		logic [`HZ_REG_W-1:0] rs;
		logic [`HZ_REG_W-1:0] rt;
		logic [`HZ_REG_W-1:0] dst;
		logic                 rfWr;     // Writes GPR
		logic                 dmRd;     // Load
		logic                 dmWr;     // Store
		logic                 cp0Rd;    // mfc0, result as late as a load
		logic                 bjOp;     // Compares in ID
		logic                 hiLoAcc;  // mfhi/mflo
	} hzStage_t;

	// Operand source for the EX muxes
	typedef enum logic [1:0] {
		FWD_NONE = 2'b00,
		FWD_MEM  = 2'b01,
		FWD_WB   = 2'b10
	} hzFwdSrc_t;

	typedef struct packed {
		hzFwdSrc_t exRs;
		hzFwdSrc_t exRt;
		logic      idRs;  // MEM to branch comparator
		logic      idRt;
	} hzFwd_t;

	typedef struct packed {
		logic pcWr;
		logic ifIdWr;
		logic idBubble;    // Squash ID into EX
		logic instSramEn;
		logic flush;
	} hzCtrl_t;

endpackage

`default_nettype wire

/* source/hazard_consts.svh */
`ifndef HAZARD_CONSTS_SVH
`define HAZARD_CONSTS_SVH

// GPR index width
`define HZ_REG_W 5

// $zero, hardwired, never a real producer
`define HZ_ZERO_REG 5'd0

`endif

/* source/pipeHazardCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeHazardCtrl import hazardPkg::*; (
	input  wire logic clk,
	input  wire logic rst,
	input  hzStage_t  idInfo,
	input  wire logic memEx,
	input  wire logic eretFlush,
	input  wire logic mdBusy,
	input  wire logic iCacheDataOk,
	input  wire logic dCacheDataOk,
	output hzFwd_t    fwd,
	output hzCtrl_t   ctrl,
	output logic      isStall,
	output logic      dcacheStall
);

	hzStage_t exQ;
	hzStage_t memQ;
	hzStage_t wbQ;

	logic exHold;
	logic exBubble;
	logic memHold;
	logic memBubble;
	logic wbHold;

	stageReg #(
		.PAYLOAD_T(hzStage_t)
	) exStage (
		.clk   (clk),
		.rst   (rst),
		.hold  (exHold),
		.bubble(exBubble),
		.d     (idInfo),
		.q     (exQ)
	);

	stageReg #(
		.PAYLOAD_T(hzStage_t)
	) memStage (
		.clk   (clk),
		.rst   (rst),
		.hold  (memHold),
		.bubble(memBubble),
		.d     (exQ),
		.q     (memQ)
	);

	// WB only ever holds or advances
	stageReg #(
		.PAYLOAD_T(hzStage_t)
	) wbStage (
		.clk   (clk),
		.rst   (rst),
		.hold  (wbHold),
		.bubble(1'b0),
		.d     (memQ),
		.q     (wbQ)
	);

	forwardUnit fwdUnit (
		.idInfo(idInfo),
		.exQ   (exQ),
		.memQ  (memQ),
		.wbQ   (wbQ),
		.fwd   (fwd)
	);

	stallUnit stlUnit (
		.clk         (clk),
		.rst         (rst),
		.idInfo      (idInfo),
		.exQ         (exQ),
		.memQ        (memQ),
		.memEx       (memEx),
		.eretFlush   (eretFlush),
		.mdBusy      (mdBusy),
		.iCacheDataOk(iCacheDataOk),
		.dCacheDataOk(dCacheDataOk),
		.ctrl        (ctrl),
		.exHold      (exHold),
		.exBubble    (exBubble),
		.memHold     (memHold),
		.memBubble   (memBubble),
		.wbHold      (wbHold),
		.isStall     (isStall),
		.dcacheStall (dcacheStall)
	);

endmodule

`default_nettype wire

/* source/stageReg.sv */
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
	parameter type PAYLOAD_T = logic [7:0]
) (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic hold,
	input  wire logic bubble,
	input  PAYLOAD_T  d,
	output PAYLOAD_T  q
);

	PAYLOAD_T stageQ;

	always_ff @(posedge clk) begin
		if (!rst) begin
			stageQ <= '0;
		end else if (bubble) begin
			stageQ <= '0;  // Valid drops with the rest
		end else if (!hold) begin
			stageQ <= d;
		end
	end

	assign q = stageQ;

	// The interlock never asks one stage to freeze and squash at once
	holdBubbleExclusive: assert property (
		@(posedge clk) disable iff (!rst)
		!(hold && bubble)
	) else $error("stageReg: hold and bubble both asserted");

endmodule

`default_nettype wire

/* source/stallUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hazard_consts.svh"

module stallUnit import hazardPkg::*; (
	input  wire logic clk,
	input  wire logic rst,
	input  hzStage_t  idInfo,
	input  hzStage_t  exQ,
	input  hzStage_t  memQ,
	input  wire logic memEx,
	input  wire logic eretFlush,
	input  wire logic mdBusy,
	input  wire logic iCacheDataOk,
	input  wire logic dCacheDataOk,
	output hzCtrl_t   ctrl,
	output logic      exHold,
	output logic      exBubble,
	output logic      memHold,
	output logic      memBubble,
	output logic      wbHold,
	output logic      isStall,
	output logic      dcacheStall
);

	typedef enum logic {
		DC_FREE = 1'b0,
		DC_BUSY = 1'b1
	} dcState_t;

	dcState_t dcState;
	dcState_t dcNext;
	logic     memAccess;
	logic     flushReq;

	// Nonzero producer whose dst feeds an ID source
	function automatic logic feedsId(
		input hzStage_t producer,
		input hzStage_t consumer
	);
		feedsId = (producer.dst != `HZ_ZERO_REG) &&
			((producer.dst == consumer.rs) || (producer.dst == consumer.rt));
	endfunction

	assign memAccess = memQ.valid && (memQ.dmRd || memQ.dmWr);
	assign flushReq  = memEx || eretFlush;

	// Decode interlock, first match wins
	always_comb begin
		ctrl.pcWr       = 1'b1;
		ctrl.ifIdWr     = 1'b1;
		ctrl.instSramEn = 1'b1;
		ctrl.idBubble   = 1'b0;
		ctrl.flush      = 1'b0;
		if (flushReq) begin
			ctrl.flush = 1'b1;  // Redirect beats any stall
		end else if ((mdBusy && idInfo.hiLoAcc) ||
			(exQ.valid && (exQ.dmRd || exQ.cp0Rd) && feedsId(exQ, idInfo)) ||
			(idInfo.bjOp && memQ.valid && memQ.rfWr &&
				(memQ.dmRd || memQ.cp0Rd) && feedsId(memQ, idInfo)) ||
			(idInfo.bjOp && exQ.valid && exQ.rfWr && feedsId(exQ, idInfo))) begin
			ctrl.pcWr       = 1'b0;
			ctrl.ifIdWr     = 1'b0;
			ctrl.instSramEn = 1'b0;
			ctrl.idBubble   = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst)
			dcState <= DC_FREE;
		else
			dcState <= dcNext;
	end

	always_comb begin
		dcNext = dcState;
		case (dcState)
			DC_FREE: begin
				if (memAccess && !dCacheDataOk)
					dcNext = DC_BUSY;
			end
			DC_BUSY: begin
				if (dCacheDataOk)
					dcNext = DC_FREE;
			end
			default: dcNext = DC_FREE;
		endcase
	end

	assign dcacheStall = ((dcState == DC_BUSY) && !dCacheDataOk) ||
		((dcState == DC_FREE) && memAccess && !dCacheDataOk) ||
		!iCacheDataOk;

	assign isStall = !ctrl.pcWr || dcacheStall;

	// Freeze dominates, then flush, then the ID bubble
	assign exHold    = dcacheStall;
	assign exBubble  = !dcacheStall && (ctrl.flush || ctrl.idBubble);
	assign memHold   = dcacheStall;
	assign memBubble = !dcacheStall && ctrl.flush;
	assign wbHold    = dcacheStall;

	// Freeze must keep the outstanding access parked in MEM
	busyKeepsAccess: assert property (
		@(posedge clk) disable iff (!rst)
		(dcState == DC_BUSY) |-> memAccess
	) else $error("stallUnit: cache busy without a MEM access");

endmodule

`default_nettype wire

/* tb.f */
+incdir+source
+incdir+verif
source/hazardPkg.sv
source/stageReg.sv
source/forwardUnit.sv
source/stallUnit.sv
source/pipeHazardCtrl.sv
verif/hazardTb.sv

/* verif/hazardRef.svh */
`ifndef HAZARD_REF_SVH
`define HAZARD_REF_SVH

// Stage s produces a live GPR value for register r
function automatic logic refWrites(input hzStage_t s, input logic [`HZ_REG_W-1:0] r);
	return s.valid && s.rfWr && (r != `HZ_ZERO_REG) && (s.dst == r);
endfunction

function automatic hzFwd_t refFwd(input hzStage_t id, input hzStage_t ex,
	input hzStage_t mem, input hzStage_t wb);
	hzFwd_t f;
	f.exRs = refWrites(mem, ex.rs) ? FWD_MEM : (refWrites(wb, ex.rs) ? FWD_WB : FWD_NONE);
	f.exRt = refWrites(mem, ex.rt) ? FWD_MEM : (refWrites(wb, ex.rt) ? FWD_WB : FWD_NONE);
	f.idRs = id.bjOp && refWrites(mem, id.rs);
	f.idRt = id.bjOp && refWrites(mem, id.rt);
	return f;
endfunction

function automatic hzCtrl_t refCtrl(input hzStage_t id, input hzStage_t ex,
	input hzStage_t mem, input logic flushIn, input logic md);
	hzCtrl_t c;
	logic exFeeds;
	logic memFeeds;
	logic stall;
	exFeeds  = (ex.dst != `HZ_ZERO_REG) && ((ex.dst == id.rs) || (ex.dst == id.rt));
	memFeeds = (mem.dst != `HZ_ZERO_REG) && ((mem.dst == id.rs) || (mem.dst == id.rt));
	stall = (md && id.hiLoAcc) ||
		(ex.valid && (ex.dmRd || ex.cp0Rd) && exFeeds) ||
		(id.bjOp && mem.valid && mem.rfWr && (mem.dmRd || mem.cp0Rd) && memFeeds) ||
		(id.bjOp && ex.valid && ex.rfWr && exFeeds);
	if (flushIn)
		stall = 1'b0;  // Redirect wins
	c.flush      = flushIn;
	c.idBubble   = stall;
	c.pcWr       = !stall;
	c.ifIdWr     = !stall;
	c.instSramEn = !stall;
	return c;
endfunction

function automatic logic refDcStall(input logic busy, input hzStage_t mem,
	input logic iOk, input logic dOk);
	logic memAcc;
	memAcc = mem.valid && (mem.dmRd || mem.dmWr);
	return (!dOk && (busy || memAcc)) || !iOk;
endfunction

// Cache wait state after the edge
function automatic logic refDcNext(input logic busy, input hzStage_t mem, input logic dOk);
	logic memAcc;
	memAcc = mem.valid && (mem.dmRd || mem.dmWr);
	return busy ? !dOk : (memAcc && !dOk);
endfunction

`endif

/* verif/hazardTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hazard_consts.svh"

module hazardTb import hazardPkg::*; ();

	localparam int MAX_CYCLES = 2000;

	logic clk;
	logic rst;
	hzStage_t idInfo;
	logic memEx;
	logic eretFlush;
	logic mdBusy;
	logic iCacheDataOk;
	logic dCacheDataOk;
	hzFwd_t fwd;
	hzCtrl_t ctrl;
	logic isStall;
	logic dcacheStall;

	hzStage_t exS;  // Shadow stages
	hzStage_t memS;
	hzStage_t wbS;
	logic dcBusy;
	hzCtrl_t shCtrl;
	logic shFrz;
	hzFwd_t expFwd;
	hzCtrl_t expCtrl;
	logic expDc;
	int errCount;
	int checkCount;
	int testStart;
	int testsDone;
	int cycleCount;

	`include "hazardRef.svh"

	pipeHazardCtrl i_pipeHazardCtrl (
		.clk(clk), .rst(rst), .idInfo(idInfo), .memEx(memEx), .eretFlush(eretFlush),
		.mdBusy(mdBusy), .iCacheDataOk(iCacheDataOk), .dCacheDataOk(dCacheDataOk),
		.fwd(fwd), .ctrl(ctrl), .isStall(isStall), .dcacheStall(dcacheStall)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= MAX_CYCLES) begin
			$display("Timeout: run went past %0d cycles", MAX_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// Shadow pipeline follows the stage rules with its own controls
	always @(posedge clk) begin
		if (!rst) begin
			exS <= '0;
			memS <= '0;
			wbS <= '0;
			dcBusy <= 1'b0;
		end else begin
			shCtrl = refCtrl(idInfo, exS, memS, memEx || eretFlush, mdBusy);
			shFrz = refDcStall(dcBusy, memS, iCacheDataOk, dCacheDataOk);
			dcBusy <= refDcNext(dcBusy, memS, dCacheDataOk);
			if (!shFrz) begin
				wbS <= memS;
				memS <= shCtrl.flush ? '0 : exS;
				exS <= (shCtrl.flush || shCtrl.idBubble) ? '0 : idInfo;
			end
		end
	end

	always @(negedge clk) begin
		if (rst) begin
			expFwd = refFwd(idInfo, exS, memS, wbS);
			expCtrl = refCtrl(idInfo, exS, memS, memEx || eretFlush, mdBusy);
			expDc = refDcStall(dcBusy, memS, iCacheDataOk, dCacheDataOk);
			checkCount = checkCount + 1;
			if (fwd !== expFwd) begin
				$display("[FAIL] %0t fwd got %h exp %h", $time, fwd, expFwd);
				errCount = errCount + 1;
			end
			if (ctrl !== expCtrl) begin
				$display("[FAIL] %0t ctrl got %h exp %h", $time, ctrl, expCtrl);
				errCount = errCount + 1;
			end
			if (dcacheStall !== expDc) begin
				$display("[FAIL] %0t dcacheStall got %b exp %b", $time, dcacheStall, expDc);
				errCount = errCount + 1;
			end
			if (isStall !== (!expCtrl.pcWr || expDc)) begin
				$display("[FAIL] %0t isStall got %b exp %b", $time, isStall,
					!expCtrl.pcWr || expDc);
				errCount = errCount + 1;
			end
		end
	end

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic expectBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %b exp %b", $time, name, got, exp);
			errCount = errCount + 1;
		end
	endtask

	task automatic expectSrc(input string name, input hzFwdSrc_t got, input hzFwdSrc_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %0d exp %0d", $time, name, got, exp);
			errCount = errCount + 1;
		end
	endtask

	task automatic endTest(input string name);
		$display("Test %s finished with %0d errors", name, errCount - testStart);
		testStart = errCount;
		testsDone = testsDone + 1;
	endtask

	task automatic drain();
		step();
		idInfo = '0;
		repeat (3) step();
	endtask

	function automatic hzStage_t aluOp(input logic [4:0] dst, input logic [4:0] rs,
		input logic [4:0] rt);
		hzStage_t s;
		s = '0;
		s.valid = 1'b1;
		s.rs = rs;
		s.rt = rt;
		s.dst = dst;
		s.rfWr = 1'b1;
		return s;
	endfunction

	function automatic hzStage_t loadOp(input logic [4:0] dst, input logic [4:0] rs);
		hzStage_t s;
		s = aluOp(dst, rs, 5'd0);
		s.dmRd = 1'b1;
		return s;
	endfunction

	function automatic hzStage_t branchOp(input logic [4:0] rs, input logic [4:0] rt);
		hzStage_t s;
		s = aluOp(5'd0, rs, rt);
		s.rfWr = 1'b0;
		s.bjOp = 1'b1;
		return s;
	endfunction

	function automatic hzStage_t randInst();
		logic [31:0] a;
		hzStage_t s;
		a = $urandom;
		s.valid = a[0] | a[1];
		s.rs = {2'b00, a[4:2]};  // Small register range for frequent hits
		s.rt = {2'b00, a[7:5]};
		s.dst = {2'b00, a[10:8]};
		s.rfWr = a[11] | a[12];
		s.dmRd = a[13] & a[14];
		s.dmWr = !s.dmRd && a[15] && a[16];
		s.cp0Rd = a[17] & a[18] & a[19];
		s.bjOp = a[20] & a[21];
		s.hiLoAcc = a[22] & a[23] & a[24];
		return s;
	endfunction

	task automatic cacheWait(input logic onData);
		int n;
		hzFwd_t snap;
		n = 1 + ($urandom % 6);
		if (onData) dCacheDataOk = 1'b0;
		else iCacheDataOk = 1'b0;
		@(negedge clk);
		snap = refFwd(idInfo, exS, memS, wbS);
		for (int i = 0; i < n; i++) begin
			if (i > 0) begin
				step();
				@(negedge clk);
			end
			expectBit("dcacheStall", dcacheStall, 1'b1);
			expectBit("isStall", isStall, 1'b1);
			if (fwd !== snap) begin
				$display("[FAIL] %0t fwd got %h exp %h", $time, fwd, snap);
				errCount = errCount + 1;
			end
		end
		step();
		dCacheDataOk = 1'b1;
		iCacheDataOk = 1'b1;
		@(negedge clk);
		expectBit("dcacheStall", dcacheStall, 1'b0);
	endtask

	initial begin
		logic [31:0] r;
		void'($urandom(40960));
		rst = 1'b0;
		idInfo = '0;
		memEx = 1'b0;
		eretFlush = 1'b0;
		mdBusy = 1'b0;
		iCacheDataOk = 1'b1;
		dCacheDataOk = 1'b1;
		errCount = 0;
		checkCount = 0;
		testStart = 0;
		testsDone = 0;
		cycleCount = 0;
		repeat (5) @(posedge clk);
		#1 rst = 1'b1;

		step();
		idInfo = aluOp(5'd5, 5'd1, 5'd2);
		step();
		idInfo = aluOp(5'd5, 5'd3, 5'd4);
		step();
		idInfo = aluOp(5'd7, 5'd5, 5'd0);
		step();
		idInfo = branchOp(5'd5, 5'd0);
		@(negedge clk);
		expectSrc("fwd.exRs", fwd.exRs, FWD_MEM);  // MEM beats WB
		expectSrc("fwd.exRt", fwd.exRt, FWD_NONE);
		expectBit("fwd.idRs", fwd.idRs, 1'b1);
		step();
		idInfo = branchOp(5'd5, 5'd7);  // r5 now only in WB
		@(negedge clk);
		expectBit("fwd.idRs", fwd.idRs, 1'b0);
		expectBit("fwd.idRt", fwd.idRt, 1'b1);
		step();
		idInfo = aluOp(5'd0, 5'd1, 5'd2);
		step();
		idInfo = aluOp(5'd9, 5'd0, 5'd0);
		step();
		idInfo = '0;
		@(negedge clk);
		expectSrc("fwd.exRs", fwd.exRs, FWD_NONE);
		drain();
		endTest("forwarding");

		step();
		idInfo = loadOp(5'd8, 5'd1);
		step();
		idInfo = aluOp(5'd9, 5'd8, 5'd2);
		@(negedge clk);
		expectBit("ctrl.pcWr", ctrl.pcWr, 1'b0);
		expectBit("ctrl.ifIdWr", ctrl.ifIdWr, 1'b0);
		expectBit("ctrl.instSramEn", ctrl.instSramEn, 1'b0);
		expectBit("ctrl.idBubble", ctrl.idBubble, 1'b1);
		step();
		@(negedge clk);
		expectBit("ctrl.pcWr", ctrl.pcWr, 1'b1);  // Bubble in EX, no repeat
		drain();
		endTest("load-use");

		step();
		idInfo = aluOp(5'd10, 5'd1, 5'd2);
		step();
		idInfo = branchOp(5'd10, 5'd0);
		@(negedge clk);
		expectBit("ctrl.pcWr", ctrl.pcWr, 1'b0);
		step();
		@(negedge clk);
		expectBit("ctrl.pcWr", ctrl.pcWr, 1'b1);
		step();
		idInfo = loadOp(5'd11, 5'd1);
		step();
		idInfo = branchOp(5'd0, 5'd11);
		@(negedge clk);
		expectBit("ctrl.pcWr", ctrl.pcWr, 1'b0);
		step();
		@(negedge clk);
		expectBit("ctrl.pcWr", ctrl.pcWr, 1'b0);  // Load now in MEM
		step();
		@(negedge clk);
		expectBit("ctrl.pcWr", ctrl.pcWr, 1'b1);
		step();
		mdBusy = 1'b1;
		idInfo = aluOp(5'd12, 5'd0, 5'd0);
		idInfo.hiLoAcc = 1'b1;
		repeat (3) begin
			@(negedge clk);
			expectBit("ctrl.pcWr", ctrl.pcWr, 1'b0);
			step();
		end
		mdBusy = 1'b0;
		@(negedge clk);
		expectBit("ctrl.pcWr", ctrl.pcWr, 1'b1);
		drain();
		endTest("branch and HI/LO");

		step();
		idInfo = loadOp(5'd13, 5'd1);
		step();
		idInfo = aluOp(5'd14, 5'd2, 5'd3);
		step();
		idInfo = branchOp(5'd13, 5'd14);  // Taps MEM, so a moving pipe shows
		cacheWait(1'b1);
		step();
		cacheWait(1'b0);
		drain();
		endTest("cache wait");

		step();
		idInfo = aluOp(5'd14, 5'd1, 5'd2);
		step();
		idInfo = loadOp(5'd15, 5'd1);
		step();
		idInfo = aluOp(5'd16, 5'd15, 5'd14);
		memEx = 1'b1;
		@(negedge clk);
		expectBit("ctrl.flush", ctrl.flush, 1'b1);
		expectBit("ctrl.pcWr", ctrl.pcWr, 1'b1);
		expectBit("ctrl.idBubble", ctrl.idBubble, 1'b0);
		step();
		memEx = 1'b0;
		idInfo = aluOp(5'd17, 5'd14, 5'd15);
		step();
		idInfo = '0;
		@(negedge clk);
		expectSrc("fwd.exRs", fwd.exRs, FWD_NONE);
		expectSrc("fwd.exRt", fwd.exRt, FWD_NONE);
		step();
		eretFlush = 1'b1;
		@(negedge clk);
		expectBit("ctrl.flush", ctrl.flush, 1'b1);
		step();
		eretFlush = 1'b0;
		drain();
		endTest("flush");

		repeat (1500) begin
			step();
			r = $urandom;
			idInfo = randInst();
			memEx = (r[5:0] == 6'd0);
			eretFlush = (r[11:6] == 6'd0);
			mdBusy = r[12] & r[13];
			dCacheDataOk = r[14] | r[15];
			iCacheDataOk = r[16] | r[17] | r[18];
		end
		step();
		memEx = 1'b0;
		eretFlush = 1'b0;
		dCacheDataOk = 1'b1;
		iCacheDataOk = 1'b1;
		@(negedge clk);
		endTest("random mix");

		$display("Done: %0d tests, %0d checks, %0d errors", testsDone, checkCount, errCount);
		if (errCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
